//--- reconstructUv.f
+incdir+tests
source/codecPkg.sv
source/quantPkg.sv
source/forwardTransform.sv
source/quantizeBlock.sv
source/inverseTransform.sv
source/reconstructUv.sv
tests/reconstructUvTb.sv

//--- tests/reconstructUvModel.svh
/*
 * Reference model for chroma reconstruction
 * Forward transform, quantizer, inverse transform and xorshift generator
 */
`ifndef RECONSTRUCT_UV_MODEL_SVH
`define RECONSTRUCT_UV_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Block index of pixel i of subblock k
function automatic int subPos(input int k, input int i);
    return ((k / 2) * 4 + i / 4) * 8 + (k % 2) * 4 + i % 4;
endfunction

function automatic logic [15:0][15:0] fwdModel(input logic [15:0][7:0] s,
                                               input logic [15:0][7:0] p);
    int t[16];
    int d0, d1, d2, d3;
    logic [15:0][15:0] o;
    for (int r = 0; r < 4; r++) begin
        d0 = int'(s[r*4]) - int'(p[r*4]) + int'(s[r*4+3]) - int'(p[r*4+3]);
        d3 = int'(s[r*4]) - int'(p[r*4]) - int'(s[r*4+3]) + int'(p[r*4+3]);
        d1 = int'(s[r*4+1]) - int'(p[r*4+1]) + int'(s[r*4+2]) - int'(p[r*4+2]);
        d2 = int'(s[r*4+1]) - int'(p[r*4+1]) - int'(s[r*4+2]) + int'(p[r*4+2]);
        t[r*4] = (d0 + d1) * 8;
        t[r*4+1] = (d2 * codecPkg::K_FWD_A + d3 * codecPkg::K_FWD_B + 1812) >>> 9;
        t[r*4+2] = (d0 - d1) * 8;
        t[r*4+3] = (d3 * codecPkg::K_FWD_A - d2 * codecPkg::K_FWD_B + 937) >>> 9;
    end
    for (int c = 0; c < 4; c++) begin
        d0 = t[c] + t[12+c];
        d1 = t[4+c] + t[8+c];
        d2 = t[4+c] - t[8+c];
        d3 = t[c] - t[12+c];
        o[c] = 16'((d0 + d1 + 7) >>> 4);
        o[4+c] = 16'(((d2 * codecPkg::K_FWD_A + d3 * codecPkg::K_FWD_B + 12000) >>> 16)
            + ((d3 != 0) ? 1 : 0));
        o[8+c] = 16'((d0 - d1 + 7) >>> 4);
        o[12+c] = 16'((d3 * codecPkg::K_FWD_A - d2 * codecPkg::K_FWD_B + 51000) >>> 16);
    end
    return o;
endfunction

function automatic int quantModel(input int c, input int iq);
    longint m;
    int l;
    m = (c < 0) ? -c : c;
    l = int'((m * iq + quantPkg::Q_BIAS) >>> quantPkg::QFIX);
    return (c < 0) ? -l : l;
endfunction

function automatic longint mul1(input longint x);
    return x + ((x * codecPkg::K_INV_A) >>> 16);
endfunction

function automatic longint mul2(input longint x);
    return (x * codecPkg::K_INV_B) >>> 16;
endfunction

function automatic logic [15:0][7:0] invModel(input logic [15:0][15:0] c,
                                              input logic [15:0][7:0] p);
    longint t[16];
    longint x[4];
    longint a, b, cc, d, v;
    logic [15:0][7:0] o;
    for (int col = 0; col < 4; col++) begin
        for (int j = 0; j < 4; j++) begin
            x[j] = $signed(c[j*4+col]);
        end
        a = x[0] + x[2];
        b = x[0] - x[2];
        cc = mul2(x[1]) - mul1(x[3]);
        d = mul1(x[1]) + mul2(x[3]);
        t[col] = a + d;
        t[4+col] = b + cc;
        t[8+col] = b - cc;
        t[12+col] = a - d;
    end
    for (int r = 0; r < 4; r++) begin
        a = t[r*4] + 4 + t[r*4+2];
        b = t[r*4] + 4 - t[r*4+2];
        cc = mul2(t[r*4+1]) - mul1(t[r*4+3]);
        d = mul1(t[r*4+1]) + mul2(t[r*4+3]);
        x[0] = a + d;
        x[1] = b + cc;
        x[2] = b - cc;
        x[3] = a - d;
        for (int j = 0; j < 4; j++) begin
            v = (x[j] >>> 3) + longint'(p[r*4+j]);
            o[r*4+j] = (v < 0) ? 8'd0 : ((v > 255) ? 8'd255 : 8'(v));
        end
    end
    return o;
endfunction

task automatic blockModel(input logic [63:0][7:0] src, input logic [63:0][7:0] pred,
                          input int qDc, input int qAc, input int iqDc, input int iqAc,
                          output logic [63:0][15:0] lv, output logic [63:0][7:0] rc,
                          output logic [3:0] nz);
    logic [15:0][7:0] s, p, pix;
    logic [15:0][15:0] coef, deq;
    int lvl;
    for (int k = 0; k < 4; k++) begin
        for (int i = 0; i < 16; i++) begin
            s[i] = src[subPos(k, i)];
            p[i] = pred[subPos(k, i)];
        end
        coef = fwdModel(s, p);
        nz[k] = 1'b0;
        for (int i = 0; i < 16; i++) begin
            lvl = quantModel($signed(coef[i]), (i == 0) ? iqDc : iqAc);
            lv[k*16+i] = 16'(lvl);
            deq[i] = 16'(lvl * ((i == 0) ? qDc : qAc));
            nz[k] = nz[k] | (lvl != 0);
        end
        pix = invModel(deq, p);
        for (int i = 0; i < 16; i++) begin
            rc[subPos(k, i)] = pix[i];
        end
    end
endtask

`endif

//--- tests/reconstructUvTb.sv
/*
 * Testbench for chroma block reconstruction
 * Drives blocks through the DUT and checks them against the model
 */
module reconstructUvTb;

    localparam int RESET_CYCLES = 4;
    localparam int BLOCKS       = 36;
    localparam int CYCLE_LIMIT  = 40 * BLOCKS + RESET_CYCLES;

    logic clk, rst_n, inValid_i, inReady_o, outValid_o, outReady_i;
    logic [63:0][7:0] srcBlock_i, predBlock_i, recon_o;
    logic [15:0] qDc_i, qAc_i, iqDc_i, iqAc_i;
    logic [63:0][15:0] levels_o;
    logic [3:0] nz_o;

    logic [63:0][7:0] srcV, predV, expRc, holdRc;
    logic [63:0][15:0] expLv, holdLv;
    logic [3:0] expNz, holdNz;
    int qDcV, qAcV, iqDcV, iqAcV;
    logic [31:0] rngState;
    int cycleCount, testErrors, passCount, failCount;

    `include "reconstructUvModel.svh"

    reconstructUv u_reconstructUv (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, the DUT did not finish", cycleCount);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    task automatic checkValue(input string name, input string what, input int idx,
                              input int exp, input int act);
        assert (exp == act) else begin
            $display("error %s %s[%0d] expected %0d actual %0d", name, what, idx, exp, act);
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("test %s ok", name);
        end else begin
            failCount++;
            $display("test %s FAILED with %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic randomData(input int qLo, input int qSpan);
        for (int i = 0; i < 64; i++) begin
            srcV[i] = 8'(nextRand() % 256);
            predV[i] = 8'(nextRand() % 256);
        end
        qDcV = qLo + nextRand() % qSpan;
        qAcV = qLo + nextRand() % qSpan;
        iqDcV = (1 << quantPkg::QFIX) / qDcV;
        iqAcV = (1 << quantPkg::QFIX) / qAcV;
    endtask

    task automatic driveInputs();
        @(posedge clk);
        inValid_i <= 1'b1;
        srcBlock_i <= srcV;
        predBlock_i <= predV;
        qDc_i <= 16'(qDcV);
        qAc_i <= 16'(qAcV);
        iqDc_i <= 16'(iqDcV);
        iqAc_i <= 16'(iqAcV);
    endtask

    // Returns on the acceptance edge
    task automatic awaitAccept();
        logic ready;
        do begin
            @(negedge clk);
            ready = inReady_o;
            @(posedge clk);
        end while (!ready);
        inValid_i <= 1'b0;
    endtask

    // Counts cycles from the acceptance edge until outValid_o is seen
    task automatic awaitOutput(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!outValid_o);
        checkValue(name, "latency", 0, 10, n - 1);
    endtask

    task automatic compareOutputs(input string name);
        for (int i = 0; i < 64; i++) begin
            checkValue(name, "levels", i, $signed(expLv[i]), $signed(levels_o[i]));
            checkValue(name, "recon", i, expRc[i], recon_o[i]);
        end
        checkValue(name, "nz", 0, expNz, nz_o);
    endtask

    task automatic runBlock(input string name);
        blockModel(srcV, predV, qDcV, qAcV, iqDcV, iqAcV, expLv, expRc, expNz);
        driveInputs();
        awaitAccept();
        awaitOutput(name);
        compareOutputs(name);
        @(posedge clk);
    endtask

    initial begin
        int k, stall;
        rngState = 32'h81f733e4;
        cycleCount = 0;
        testErrors = 0;
        passCount = 0;
        failCount = 0;
        rst_n = 1'b0;
        inValid_i = 1'b0;
        outReady_i = 1'b1;
        srcBlock_i = '0;
        predBlock_i = '0;
        qDc_i = '0;
        qAc_i = '0;
        iqDc_i = '0;
        iqAc_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        checkValue("reset", "outValid_o", 0, 0, outValid_o);
        checkValue("reset", "inReady_o", 0, 1, inReady_o);
        randomData(4, 60);
        runBlock("reset");
        endTest("reset");

        // Zero residual
        randomData(4, 60);
        srcV = predV;
        runBlock("zero");
        checkValue("zero", "nz", 0, 0, nz_o);
        for (int i = 0; i < 64; i++) begin
            checkValue("zero", "levels", i, 0, levels_o[i]);
            checkValue("zero", "recon", i, predV[i], recon_o[i]);
        end
        endTest("zero");

        for (int t = 0; t < 30; t++) begin
            randomData(4, 124);
            runBlock("random");
        end
        endTest("random");

        // Residual in one subblock only
        randomData(4, 8);
        srcV = predV;
        k = nextRand() % 4;
        for (int i = 0; i < 16; i++) begin
            srcV[subPos(k, i)] = 8'(nextRand() % 256);
        end
        runBlock("single");
        checkValue("single", "nz", 0, 1 << k, nz_o);
        for (int i = 0; i < 64; i++) begin
            if ((i / 32) * 2 + (i % 8) / 4 != k) begin
                checkValue("single", "recon", i, predV[i], recon_o[i]);
            end
        end
        endTest("single");

        // Second block waits while the first is back-pressured
        randomData(4, 124);
        blockModel(srcV, predV, qDcV, qAcV, iqDcV, iqAcV, expLv, expRc, expNz);
        @(posedge clk);
        outReady_i <= 1'b0;
        driveInputs();
        awaitAccept();
        awaitOutput("stall");
        holdLv = levels_o;
        holdRc = recon_o;
        holdNz = nz_o;
        randomData(4, 124);
        driveInputs();
        stall = 3 + nextRand() % 8;
        repeat (stall) begin
            @(negedge clk);
            assert (levels_o == holdLv && recon_o == holdRc && nz_o == holdNz) else begin
                $display("outputs changed while the consumer was stalled");
                testErrors++;
            end
            checkValue("stall", "outValid_o", 0, 1, outValid_o);
            checkValue("stall", "inReady_o", 0, 0, inReady_o);
        end
        compareOutputs("stall");
        blockModel(srcV, predV, qDcV, qAcV, iqDcV, iqAcV, expLv, expRc, expNz);
        @(posedge clk);
        outReady_i <= 1'b1;
        awaitAccept();
        awaitOutput("stall");
        compareOutputs("stall");
        @(posedge clk);
        endTest("stall");

        // Predictions at the range ends with coarse steps
        randomData(100, 28);
        for (int i = 0; i < 64; i++) begin
            predV[i] = (i % 3 == 0) ? 8'(nextRand() % 4) : 8'(252 + nextRand() % 4);
            srcV[i] = (predV[i] < 128) ? 8'(200 + nextRand() % 56) : 8'(nextRand() % 56);
        end
        runBlock("clamp");
        endTest("clamp");

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- source/reconstructUv.sv
/*
 * Chroma block reconstruction, top level
 * Feeds the four subblocks of an 8x8 block through transform, quantizer
 * and inverse transform, then holds levels, pixels and nz flags
 */
module reconstructUv (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 inValid_i,
    output logic                                                 inReady_o,
    input  logic [codecPkg::BLOCK_PIX-1:0][codecPkg::PIXEL_W-1:0] srcBlock_i,
    input  logic [codecPkg::BLOCK_PIX-1:0][codecPkg::PIXEL_W-1:0] predBlock_i,
    input  logic [quantPkg::Q_W-1:0]                             qDc_i,
    input  logic [quantPkg::Q_W-1:0]                             qAc_i,
    input  logic [quantPkg::IQ_W-1:0]                            iqDc_i,
    input  logic [quantPkg::IQ_W-1:0]                            iqAc_i,
    output logic                                                 outValid_o,
    input  logic                                                 outReady_i,
    output logic [codecPkg::BLOCK_PIX-1:0][codecPkg::COEF_W-1:0]  levels_o,
    output logic [codecPkg::BLOCK_PIX-1:0][codecPkg::PIXEL_W-1:0] recon_o,
    output logic [codecPkg::SUB_COUNT-1:0]                       nz_o
);

    logic accept, transfer, busy;
    logic [2:0] feedCnt;
    logic feedValid;
    logic [codecPkg::BLOCK_PIX-1:0][codecPkg::PIXEL_W-1:0] srcLat, predLat;
    logic [quantPkg::Q_W-1:0] qDcLat, qAcLat;
    logic [quantPkg::IQ_W-1:0] iqDcLat, iqAcLat;
    // Subblock index delayed one stage per pipeline cycle
    logic [1:0] idxPipe [6];

    logic [codecPkg::SUB_PIX-1:0][codecPkg::PIXEL_W-1:0] feedSrc, feedPred, invPred, invPix;
    logic [codecPkg::SUB_PIX-1:0][codecPkg::COEF_W-1:0] fwdCoef, quantLevel, quantDequant;
    logic fwdValid, quantValid, quantNz, invValid, invDone;

    // Block index of pixel i in subblock sub with two subblocks per block row
    function automatic int blockPos(input logic [1:0] sub, input int i);
        return (int'(sub[1]) * 4 + i / 4) * 8 + int'(sub[0]) * 4 + i % 4;
    endfunction

    function automatic logic [codecPkg::SUB_PIX-1:0][codecPkg::PIXEL_W-1:0] subSlice(
        input logic [codecPkg::BLOCK_PIX-1:0][codecPkg::PIXEL_W-1:0] blk,
        input logic [1:0] sub
    );
        logic [codecPkg::SUB_PIX-1:0][codecPkg::PIXEL_W-1:0] s;
        for (int i = 0; i < codecPkg::SUB_PIX; i++) begin
            s[i] = blk[blockPos(sub, i)];
        end
        return s;
    endfunction

    assign inReady_o = !busy;
    assign accept    = inValid_i && inReady_o;
    assign transfer  = outValid_o && outReady_i;
    assign feedValid = feedCnt < codecPkg::SUB_COUNT;
    assign feedSrc   = subSlice(srcLat, feedCnt[1:0]);
    assign feedPred  = subSlice(predLat, feedCnt[1:0]);
    assign invPred   = subSlice(predLat, idxPipe[2]);

    forwardTransform u_forwardTransform (
        .clk        (clk),
        .rst_n      (rst_n),
        .inValid_i  (feedValid),
        .src_i      (feedSrc),
        .pred_i     (feedPred),
        .outValid_o (fwdValid),
        .coef_o     (fwdCoef)
    );

    quantizeBlock u_quantizeBlock (
        .clk        (clk),
        .rst_n      (rst_n),
        .inValid_i  (fwdValid),
        .coef_i     (fwdCoef),
        .qDc_i      (qDcLat),
        .qAc_i      (qAcLat),
        .iqDc_i     (iqDcLat),
        .iqAc_i     (iqAcLat),
        .outValid_o (quantValid),
        .level_o    (quantLevel),
        .dequant_o  (quantDequant),
        .nz_o       (quantNz)
    );

    inverseTransform u_inverseTransform (
        .clk        (clk),
        .rst_n      (rst_n),
        .inValid_i  (quantValid),
        .coef_i     (quantDequant),
        .pred_i     (invPred),
        .outValid_o (invValid),
        .pix_o      (invPix)
    );

    // ----------------------------------------
    // Block handshake and feed counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            feedCnt    <= 3'(codecPkg::SUB_COUNT);
            invDone    <= 1'b0;
            outValid_o <= 1'b0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
            end else if (transfer) begin
                busy <= 1'b0;
            end
            if (accept) begin
                feedCnt <= '0;
            end else if (feedValid) begin
                feedCnt <= feedCnt + 3'd1;
            end
            invDone <= invValid;
            // Last subblock's pixels were gathered on the previous edge
            if (invDone && idxPipe[5] == 2'(codecPkg::SUB_COUNT - 1)) begin
                outValid_o <= 1'b1;
            end else if (transfer) begin
                outValid_o <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Input latch and result gathering
    always_ff @(posedge clk) begin
        if (accept) begin
            srcLat  <= srcBlock_i;
            predLat <= predBlock_i;
            qDcLat  <= qDc_i;
            qAcLat  <= qAc_i;
            iqDcLat <= iqDc_i;
            iqAcLat <= iqAc_i;
        end
        idxPipe[0] <= feedCnt[1:0];
        for (int n = 1; n < 6; n++) begin
            idxPipe[n] <= idxPipe[n-1];
        end
        if (quantValid) begin
            for (int i = 0; i < codecPkg::SUB_PIX; i++) begin
                levels_o[int'(idxPipe[2]) * codecPkg::SUB_PIX + i] <= quantLevel[i];
            end
            nz_o[idxPipe[2]] <= quantNz;
        end
        if (invValid) begin
            for (int i = 0; i < codecPkg::SUB_PIX; i++) begin
                recon_o[blockPos(idxPipe[4], i)] <= invPix[i];
            end
        end
    end

endmodule

//--- source/inverseTransform.sv
/*
 * Inverse 4x4 transform with reconstruction
 * Vertical pass in stage 1, then horizontal pass, prediction add and clip
 */
module inverseTransform (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               inValid_i,
    input  logic [codecPkg::SUB_PIX-1:0][codecPkg::COEF_W-1:0]  coef_i,
    input  logic [codecPkg::SUB_PIX-1:0][codecPkg::PIXEL_W-1:0] pred_i,
    output logic                                               outValid_o,
    output logic [codecPkg::SUB_PIX-1:0][codecPkg::PIXEL_W-1:0] pix_o
);

    logic signed [codecPkg::COEF_W+1:0] vPass [codecPkg::SUB_PIX];
    logic signed [codecPkg::COEF_W+1:0] vReg  [codecPkg::SUB_PIX];
    logic [codecPkg::SUB_PIX-1:0][codecPkg::PIXEL_W-1:0] predReg;
    logic [codecPkg::SUB_PIX-1:0][codecPkg::PIXEL_W-1:0] pixNext;
    logic midValid;

    // x * (1 + 20091/65536)
    function automatic logic signed [39:0] mulA(input logic signed [39:0] x);
        return x + ((x * codecPkg::K_INV_A) >>> 16);
    endfunction

    function automatic logic signed [39:0] mulB(input logic signed [39:0] x);
        return (x * codecPkg::K_INV_B) >>> 16;
    endfunction

    function automatic logic [codecPkg::PIXEL_W-1:0] clip(input logic signed [39:0] v);
        if (v < 0) begin
            return '0;
        end
        if (v > (1 << codecPkg::PIXEL_W) - 1) begin
            return '1;
        end
        return v[codecPkg::PIXEL_W-1:0];
    endfunction

    // ----------------------------------------
    // Vertical pass, one column per iteration
    always_comb begin
        logic signed [39:0] x0, x1, x2, x3;
        logic signed [39:0] a, b, cc, d;
        logic signed [39:0] res [4];
        for (int c = 0; c < 4; c++) begin
            x0 = $signed(coef_i[c]);
            x1 = $signed(coef_i[4 + c]);
            x2 = $signed(coef_i[8 + c]);
            x3 = $signed(coef_i[12 + c]);
            a  = x0 + x2;
            b  = x0 - x2;
            cc = mulB(x1) - mulA(x3);
            d  = mulA(x1) + mulB(x3);
            res[0] = a + d;
            res[1] = b + cc;
            res[2] = b - cc;
            res[3] = a - d;
            for (int j = 0; j < 4; j++) begin
                vPass[j*4 + c] = res[j][codecPkg::COEF_W+1:0];
            end
        end
    end

    // ----------------------------------------
    // Horizontal pass, add prediction, clip
    always_comb begin
        logic signed [39:0] dc, a, b, cc, d;
        logic signed [39:0] res [4];
        for (int r = 0; r < 4; r++) begin
            dc = vReg[r*4] + 4;
            a  = dc + vReg[r*4 + 2];
            b  = dc - vReg[r*4 + 2];
            cc = mulB(vReg[r*4 + 1]) - mulA(vReg[r*4 + 3]);
            d  = mulA(vReg[r*4 + 1]) + mulB(vReg[r*4 + 3]);
            res[0] = a + d;
            res[1] = b + cc;
            res[2] = b - cc;
            res[3] = a - d;
            for (int x = 0; x < 4; x++) begin
                pixNext[r*4 + x] = clip((res[x] >>> 3) + $signed({1'b0, predReg[r*4 + x]}));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            midValid   <= 1'b0;
            outValid_o <= 1'b0;
        end else begin
            midValid   <= inValid_i;
            outValid_o <= midValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid_i) begin
            vReg    <= vPass;
            predReg <= pred_i;
        end
        if (midValid) begin
            pix_o <= pixNext;
        end
    end

endmodule

//--- source/quantizeBlock.sv
/*
 * Quantizer for one 4x4 coefficient subblock
 * Produces levels, dequantized coefficients and a non-zero flag
 */
module quantizeBlock (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              inValid_i,
    input  logic [codecPkg::SUB_PIX-1:0][codecPkg::COEF_W-1:0] coef_i,
    input  logic [quantPkg::Q_W-1:0]                          qDc_i,
    input  logic [quantPkg::Q_W-1:0]                          qAc_i,
    input  logic [quantPkg::IQ_W-1:0]                         iqDc_i,
    input  logic [quantPkg::IQ_W-1:0]                         iqAc_i,
    output logic                                              outValid_o,
    output logic [codecPkg::SUB_PIX-1:0][codecPkg::COEF_W-1:0] level_o,
    output logic [codecPkg::SUB_PIX-1:0][codecPkg::COEF_W-1:0] dequant_o,
    output logic                                              nz_o
);

    logic [codecPkg::SUB_PIX-1:0][codecPkg::COEF_W-1:0] levelNext;
    logic [codecPkg::SUB_PIX-1:0][codecPkg::COEF_W-1:0] dequantNext;
    logic nzNext;

    always_comb begin
        codecPkg::coef_t c;
        codecPkg::coef_t lvl;
        logic [codecPkg::COEF_W-1:0] mag;
        logic [quantPkg::Q_W-1:0] q;
        logic [quantPkg::IQ_W-1:0] iq;
        logic [codecPkg::COEF_W+quantPkg::IQ_W:0] scaled;
        logic signed [codecPkg::COEF_W+quantPkg::Q_W:0] dq;
        nzNext = 1'b0;
        for (int i = 0; i < codecPkg::SUB_PIX; i++) begin
            c = coef_i[i];
            // DC step for coefficient 0 only
            q  = (i == 0) ? qDc_i : qAc_i;
            iq = (i == 0) ? iqDc_i : iqAc_i;
            mag = c[codecPkg::COEF_W-1] ? -c : c;
            scaled = mag * iq + quantPkg::Q_BIAS;
            scaled = scaled >> quantPkg::QFIX;
            lvl = scaled[codecPkg::COEF_W-1:0];
            if (c[codecPkg::COEF_W-1]) begin
                lvl = -lvl;
            end
            dq = lvl * $signed({1'b0, q});
            levelNext[i]   = lvl;
            dequantNext[i] = dq[codecPkg::COEF_W-1:0];
            nzNext = nzNext | (lvl != 0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid_o <= 1'b0;
        end else begin
            outValid_o <= inValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid_i) begin
            level_o   <= levelNext;
            dequant_o <= dequantNext;
            nz_o      <= nzNext;
        end
    end

endmodule

//--- source/forwardTransform.sv
/*
 * Forward 4x4 integer transform of one residual subblock
 * Stage 1 does the horizontal butterflies, stage 2 the vertical pass
 */
module forwardTransform (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               inValid_i,
    input  logic [codecPkg::SUB_PIX-1:0][codecPkg::PIXEL_W-1:0] src_i,
    input  logic [codecPkg::SUB_PIX-1:0][codecPkg::PIXEL_W-1:0] pred_i,
    output logic                                               outValid_o,
    output logic [codecPkg::SUB_PIX-1:0][codecPkg::COEF_W-1:0]  coef_o
);

    codecPkg::coef_t hPass [codecPkg::SUB_PIX];
    codecPkg::coef_t hReg  [codecPkg::SUB_PIX];
    logic [codecPkg::SUB_PIX-1:0][codecPkg::COEF_W-1:0] vPass;
    logic midValid;

    // ----------------------------------------
    // Residual and horizontal pass
    always_comb begin
        int d0, d1, d2, d3;
        int a0, a1, a2, a3;
        for (int r = 0; r < 4; r++) begin
            d0 = int'(src_i[r*4])     - int'(pred_i[r*4]);
            d1 = int'(src_i[r*4 + 1]) - int'(pred_i[r*4 + 1]);
            d2 = int'(src_i[r*4 + 2]) - int'(pred_i[r*4 + 2]);
            d3 = int'(src_i[r*4 + 3]) - int'(pred_i[r*4 + 3]);
            a0 = d0 + d3;
            a1 = d1 + d2;
            a2 = d1 - d2;
            a3 = d0 - d3;
            hPass[r*4] = codecPkg::coef_t'((a0 + a1) * 8);
            hPass[r*4 + 1] = codecPkg::coef_t'((a2 * codecPkg::K_FWD_A
                + a3 * codecPkg::K_FWD_B + codecPkg::FWD_RND_1A) >>> 9);
            hPass[r*4 + 2] = codecPkg::coef_t'((a0 - a1) * 8);
            hPass[r*4 + 3] = codecPkg::coef_t'((a3 * codecPkg::K_FWD_A
                - a2 * codecPkg::K_FWD_B + codecPkg::FWD_RND_1B) >>> 9);
        end
    end

    // ----------------------------------------
    // Vertical pass on the stage 1 register
    always_comb begin
        int a0, a1, a2, a3;
        for (int c = 0; c < 4; c++) begin
            a0 = int'(hReg[c]) + int'(hReg[12 + c]);
            a1 = int'(hReg[4 + c]) + int'(hReg[8 + c]);
            a2 = int'(hReg[4 + c]) - int'(hReg[8 + c]);
            a3 = int'(hReg[c]) - int'(hReg[12 + c]);
            vPass[c] = codecPkg::coef_t'((a0 + a1 + 7) >>> 4);
            // Odd row 1 gets a bump when a3 is non-zero
            vPass[4 + c] = codecPkg::coef_t'(((a2 * codecPkg::K_FWD_A
                + a3 * codecPkg::K_FWD_B + codecPkg::FWD_RND_2A) >>> 16)
                + ((a3 != 0) ? 1 : 0));
            vPass[8 + c] = codecPkg::coef_t'((a0 - a1 + 7) >>> 4);
            vPass[12 + c] = codecPkg::coef_t'((a3 * codecPkg::K_FWD_A
                - a2 * codecPkg::K_FWD_B + codecPkg::FWD_RND_2B) >>> 16);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            midValid   <= 1'b0;
            outValid_o <= 1'b0;
        end else begin
            midValid   <= inValid_i;
            outValid_o <= midValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid_i) begin
            hReg <= hPass;
        end
        if (midValid) begin
            coef_o <= vPass;
        end
    end

endmodule

//--- source/quantPkg.sv
/*
 * Quantizer constants
 * Step widths and the fixed-point format of the reciprocal steps
 */
package quantPkg;

    localparam int Q_W  = 16;
    localparam int IQ_W = 16;

    // Reciprocal steps are in Q17
    localparam int QFIX = 17;

    // Round to nearest before the shift
    localparam int Q_BIAS = 1 << (QFIX - 1);

endpackage

//--- source/codecPkg.sv
/*
 * Codec constants for chroma reconstruction
 * Block geometry, sample widths and 4x4 transform constants
 */
package codecPkg;

    localparam int PIXEL_W   = 8;
    localparam int COEF_W    = 16;
    localparam int SUB_PIX   = 16;
    localparam int SUB_COUNT = 4;
    localparam int BLOCK_PIX = 64;

    typedef logic signed [COEF_W-1:0] coef_t;

    // ----------------------------------------
    // Forward transform
    localparam int K_FWD_A    = 2217;
    localparam int K_FWD_B    = 5352;
    // Rounding terms, first and second pass
    localparam int FWD_RND_1A = 1812;
    localparam int FWD_RND_1B = 937;
    localparam int FWD_RND_2A = 12000;
    localparam int FWD_RND_2B = 51000;

    // ----------------------------------------
    // Inverse transform, Q16 multipliers
    localparam int K_INV_A = 20091;
    localparam int K_INV_B = 35468;

endpackage
